// File: Bender.yml
package:
  name: host_llc_ctrl

sources:
  - files:
      - src/llc_cfg_pkg.sv
      - src/llc_geom_pkg.sv
      - src/llc_cfg_regs.sv
      - src/llc_region_decoder.sv
      - src/llc_access_counters.sv
      - src/dma_evt_rx.sv
      - src/host_llc_ctrl.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_host_llc_ctrl.sv

// File: dv/host_llc_model.svh
// LLC reference model
`ifndef HOST_LLC_MODEL_SVH
`define HOST_LLC_MODEL_SVH

typedef struct packed {
  logic [RegionBits-1:0] region;
  logic [TagBits-1:0]    tag;
  logic [WayBits-1:0]    way;
  logic [LineBits-1:0]   line;
  logic [BlockBits-1:0]  block;
} dec_fields_t;

// Region and field rules of the request decoder
function automatic dec_fields_t decode_model(input logic [31:0] addr,
                                             input logic [31:0] cs,
                                             input logic [31:0] ce,
                                             input logic [31:0] ss);
  llc_addr_u   a;
  llc_addr_u   off;
  dec_fields_t f;
  a   = addr;
  off = addr - ss;
  f   = '0;
  if ((addr >= cs) && (addr < ce)) begin
    f.region = RegionCached;
    f.tag    = a.cache.tag;
    f.line   = a.cache.line;
    f.block  = a.cache.block;
  end else if (off < SpmBytes) begin
    f.region = RegionSpm;
    f.way    = off.spm.way;
    f.line   = off.spm.line;
    f.block  = off.spm.block;
  end else begin
    f.region = RegionBypass;
  end
  return f;
endfunction

// Expected counters after one decoded access
function automatic logic [NumCnt-1:0][31:0] count_update(input logic [NumCnt-1:0][31:0] cnt,
                                                         input logic [RegionBits-1:0] region,
                                                         input logic we);
  logic [NumCnt-1:0][31:0] next;
  next = cnt;
  if (region == RegionCached) begin
    if (we) begin
      next[CntCachedWr] = cnt[CntCachedWr] + 32'd1;
    end else begin
      next[CntCachedRd] = cnt[CntCachedRd] + 32'd1;
    end
  end else if (region == RegionSpm) begin
    next[CntSpm] = cnt[CntSpm] + 32'd1;
  end else begin
    next[CntBypass] = cnt[CntBypass] + 32'd1;
  end
  return next;
endfunction

`endif

// File: dv/tb_host_llc_ctrl.sv
// Host LLC controller testbench
`timescale 1ns/1ps
`default_nettype none

module tb_host_llc_ctrl
  import llc_cfg_pkg::*;
  import llc_geom_pkg::*;
();

  `include "host_llc_model.svh"

  localparam int HsTimeout    = 20;
  localparam int MaxRespDelay = 6;
  localparam int DmaPulses    = 12;
  localparam int RegOpCycles  = HsTimeout + MaxRespDelay + 2;
  // Worst case cycles of reset and the five tests
  localparam int TotalCycles  = 16 + 8 * RegOpCycles + 21 * RegOpCycles
                                + 4 * (3 * RegOpCycles + 50 * 4)
                                + 20 * RegOpCycles + 80 * 2 + 4 + DmaPulses * 24;
  localparam int WatchdogNs   = TotalCycles * 8 + 1000;

  logic                     clk_i;
  logic                     reset_i;
  logic                     wr_valid_i;
  logic [LiteAddrWidth-1:0] wr_addr_i;
  logic [LiteDataWidth-1:0] wr_data_i;
  logic                     wr_ready_o;
  logic                     wr_resp_valid_o;
  logic                     wr_resp_ready_i;
  logic                     rd_valid_i;
  logic [LiteAddrWidth-1:0] rd_addr_i;
  logic                     rd_ready_o;
  logic                     rd_resp_valid_o;
  logic [LiteDataWidth-1:0] rd_data_o;
  logic                     rd_resp_ready_i;
  logic                     req_valid_i;
  logic                     req_we_i;
  logic [AddrBits-1:0]      req_addr_i;
  logic                     dec_valid_o;
  logic                     dec_we_o;
  logic [RegionBits-1:0]    dec_region_o;
  logic [TagBits-1:0]       dec_tag_o;
  logic [WayBits-1:0]       dec_way_o;
  logic [LineBits-1:0]      dec_line_o;
  logic [BlockBits-1:0]     dec_block_o;
  logic                     dma_evt_valid_i;
  logic                     dma_evt_o;
  logic                     dma_evt_ack_o;

  logic [31:0]              rng_state;
  logic [31:0]              win_cs;
  logic [31:0]              win_ce;
  logic [31:0]              win_ss;
  logic [NumCnt-1:0][31:0]  exp_cnt;
  logic                     evt_q1;
  logic                     evt_q2;
  logic                     evt_q3;
  string                    test_name;
  int                       errors;
  int                       test_errors;
  int                       checks;
  int                       tests;

  host_llc_ctrl i_host_llc_ctrl (
    .clk_i           ( clk_i           ),
    .reset_i         ( reset_i         ),
    .wr_valid_i      ( wr_valid_i      ),
    .wr_addr_i       ( wr_addr_i       ),
    .wr_data_i       ( wr_data_i       ),
    .wr_ready_o      ( wr_ready_o      ),
    .wr_resp_valid_o ( wr_resp_valid_o ),
    .wr_resp_ready_i ( wr_resp_ready_i ),
    .rd_valid_i      ( rd_valid_i      ),
    .rd_addr_i       ( rd_addr_i       ),
    .rd_ready_o      ( rd_ready_o      ),
    .rd_resp_valid_o ( rd_resp_valid_o ),
    .rd_data_o       ( rd_data_o       ),
    .rd_resp_ready_i ( rd_resp_ready_i ),
    .req_valid_i     ( req_valid_i     ),
    .req_we_i        ( req_we_i        ),
    .req_addr_i      ( req_addr_i      ),
    .dec_valid_o     ( dec_valid_o     ),
    .dec_we_o        ( dec_we_o        ),
    .dec_region_o    ( dec_region_o    ),
    .dec_tag_o       ( dec_tag_o       ),
    .dec_way_o       ( dec_way_o       ),
    .dec_line_o      ( dec_line_o      ),
    .dec_block_o     ( dec_block_o     ),
    .dma_evt_valid_i ( dma_evt_valid_i ),
    .dma_evt_o       ( dma_evt_o       ),
    .dma_evt_ack_o   ( dma_evt_ack_o   )
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  initial begin
    #(WatchdogNs);
    $display("Watchdog expired before the tests finished");
    $display("Verification failed");
    $finish;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] rand_word();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic int unsigned rand_below(input int unsigned n);
    return rand_word() % n;
  endfunction

  // Inputs change and outputs are sampled 1 ns after the edge
  task automatic step();
    @(posedge clk_i);
    #1;
  endtask

  task automatic note_error(input string what);
    $display("Error in %s: %s", test_name, what);
    errors++;
    test_errors++;
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      $display("Fail %s %s: expected %0b, actual %0b", test_name, what, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_word(input string what, input logic [LiteDataWidth-1:0] exp,
                            input logic [LiteDataWidth-1:0] act);
    checks++;
    if (act !== exp) begin
      $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_region(input string what, input logic [RegionBits-1:0] exp,
                              input logic [RegionBits-1:0] act);
    checks++;
    if (act !== exp) begin
      $display("Fail %s %s: expected %0d, actual %0d", test_name, what, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  // Tag, way, line and block together
  task automatic check_fields(input string what, input dec_fields_t exp, input dec_fields_t act);
    checks++;
    if ({act.tag, act.way, act.line, act.block} !== {exp.tag, exp.way, exp.line, exp.block}) begin
      $display("Fail %s %s: expected %h/%h/%h/%h, actual %h/%h/%h/%h", test_name, what,
               exp.tag, exp.way, exp.line, exp.block, act.tag, act.way, act.line, act.block);
      errors++;
      test_errors++;
    end
  endtask

  task automatic finish_test();
    tests++;
    if (test_errors == 0) begin
      $display("%s done, no errors", test_name);
    end else begin
      $display("%s done, %0d errors", test_name, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic reg_write(input logic [31:0] addr, input logic [31:0] data, input int delay);
    int waits;
    waits      = 0;
    wr_valid_i = 1'b1;
    wr_addr_i  = addr;
    wr_data_i  = data;
    while (!wr_ready_o && waits < HsTimeout) begin
      step();
      waits++;
    end
    if (!wr_ready_o) begin
      note_error("write request was never accepted");
      wr_valid_i = 1'b0;
      return;
    end
    step();
    wr_valid_i = 1'b0;
    if (!wr_resp_valid_o) begin
      note_error("write response did not follow the request");
      return;
    end
    repeat (delay) begin
      step();
      if (!wr_resp_valid_o) note_error("write response dropped before it was taken");
      if (wr_ready_o) note_error("write ready high while a response was pending");
    end
    wr_resp_ready_i = 1'b1;
    step();
    wr_resp_ready_i = 1'b0;
    if (wr_resp_valid_o) note_error("write response stayed high after it was taken");
  endtask

  task automatic reg_read(input logic [31:0] addr, input int delay, output logic [31:0] data);
    int          waits;
    logic [31:0] held;
    waits      = 0;
    data       = '0;
    rd_valid_i = 1'b1;
    rd_addr_i  = addr;
    while (!rd_ready_o && waits < HsTimeout) begin
      step();
      waits++;
    end
    if (!rd_ready_o) begin
      note_error("read request was never accepted");
      rd_valid_i = 1'b0;
      return;
    end
    step();
    rd_valid_i = 1'b0;
    if (!rd_resp_valid_o) begin
      note_error("read response did not follow the request");
      return;
    end
    held = rd_data_o;
    repeat (delay) begin
      step();
      if (!rd_resp_valid_o) note_error("read response dropped before it was taken");
      if (rd_ready_o) note_error("read ready high while a response was pending");
      check_word("held read data", held, rd_data_o);
    end
    rd_resp_ready_i = 1'b1;
    step();
    rd_resp_ready_i = 1'b0;
    if (rd_resp_valid_o) note_error("read response stayed high after it was taken");
    data = held;
  endtask

  task automatic read_expect(input string what, input logic [31:0] addr, input logic [31:0] exp);
    logic [31:0] data;
    reg_read(addr, rand_below(MaxRespDelay + 1), data);
    check_word(what, exp, data);
  endtask

  task automatic set_windows(input logic [31:0] cs, input logic [31:0] ce, input logic [31:0] ss);
    reg_write(AddrCachedStart, cs, rand_below(MaxRespDelay + 1));
    reg_write(AddrCachedEnd, ce, rand_below(MaxRespDelay + 1));
    reg_write(AddrSpmStart, ss, rand_below(MaxRespDelay + 1));
    win_cs = cs;
    win_ce = ce;
    win_ss = ss;
  endtask

  // Leaves req_valid_i high for the caller to drop
  task automatic issue_request(input logic [31:0] addr, input logic we);
    dec_fields_t exp_f;
    dec_fields_t act_f;
    exp_f       = decode_model(addr, win_cs, win_ce, win_ss);
    req_valid_i = 1'b1;
    req_addr_i  = addr;
    req_we_i    = we;
    step();
    act_f = {dec_region_o, dec_tag_o, dec_way_o, dec_line_o, dec_block_o};
    check_bit("decode valid", 1'b1, dec_valid_o);
    check_bit("decode direction", we, dec_we_o);
    check_region("region", exp_f.region, dec_region_o);
    check_fields("fields", exp_f, act_f);
    exp_cnt = count_update(exp_cnt, exp_f.region, we);
  endtask

  // Expected ack is the level two edges back and the pulse marks its rise
  task automatic dma_cycle(input logic lvl, inout int rises, inout int pulses);
    if (lvl && !dma_evt_valid_i) rises++;
    dma_evt_valid_i = lvl;
    step();
    evt_q3 = evt_q2;
    evt_q2 = evt_q1;
    evt_q1 = lvl;
    check_bit("event ack", evt_q2, dma_evt_ack_o);
    check_bit("event pulse", evt_q2 & ~evt_q3, dma_evt_o);
    if (dma_evt_o) pulses++;
  endtask

  initial begin
    logic [31:0] cs;
    logic [31:0] ce;
    logic [31:0] ss;
    logic [31:0] addr;
    logic [31:0] jitter;
    int          rises;
    int          pulses;
    int          len;
    int          gap;

    // Request and event inputs stay active through reset
    reset_i         = 1'b1;
    wr_valid_i      = 1'b0;
    wr_addr_i       = '0;
    wr_data_i       = '0;
    wr_resp_ready_i = 1'b0;
    rd_valid_i      = 1'b0;
    rd_addr_i       = '0;
    rd_resp_ready_i = 1'b0;
    req_valid_i     = 1'b1;
    req_we_i        = 1'b0;
    req_addr_i      = '0;
    dma_evt_valid_i = 1'b1;
    rng_state       = 32'h664f_e220;
    exp_cnt         = '0;
    win_cs          = CachedStartReset;
    win_ce          = CachedEndReset;
    win_ss          = SpmStartReset;
    evt_q1          = 1'b0;
    evt_q2          = 1'b0;
    evt_q3          = 1'b0;
    errors          = 0;
    test_errors     = 0;
    checks          = 0;
    tests           = 0;
    repeat (16) step();
    reset_i         = 1'b0;
    req_valid_i     = 1'b0;
    dma_evt_valid_i = 1'b0;

    test_name = "reset_state";
    check_bit("write response valid", 1'b0, wr_resp_valid_o);
    check_bit("read response valid", 1'b0, rd_resp_valid_o);
    check_bit("decode valid", 1'b0, dec_valid_o);
    check_bit("event pulse", 1'b0, dma_evt_o);
    check_bit("event ack", 1'b0, dma_evt_ack_o);
    read_expect("cached start", AddrCachedStart, 32'h8000_0000);
    read_expect("cached end", AddrCachedEnd, 32'h8800_0000);
    read_expect("spm start", AddrSpmStart, 32'h7000_0000);
    for (int i = 0; i < NumCnt; i++) begin
      read_expect("counter", AddrCntCachedRd + 32'(i * 4), 32'h0);
    end
    read_expect("unmapped", 32'h20, 32'hdeadf000);
    finish_test();

    test_name = "window_writes";
    for (int r = 0; r < 3; r++) begin
      set_windows(rand_word(), rand_word(), rand_word());
      // Unmapped write is accepted and has no effect
      reg_write(32'h24, rand_word(), rand_below(MaxRespDelay + 1));
      read_expect("cached start", AddrCachedStart, win_cs);
      read_expect("cached end", AddrCachedEnd, win_ce);
      read_expect("spm start", AddrSpmStart, win_ss);
    end
    finish_test();

    test_name = "region_decode";
    for (int r = 0; r < 4; r++) begin
      cs = rand_word() & 32'hfff0_0000;
      case (r)
        0: begin
          ce = cs + (rand_word() & 32'h00ff_fff8);
          ss = rand_word() & 32'hffff_fff8;
        end
        1: begin
          ce = cs + 32'h0004_0000;
          ss = cs + (rand_word() & 32'h0003_fff8);
        end
        2: begin
          ce = cs + 32'h0010_0000;
          ss = ce - 32'h0001_0000;
        end
        default: begin
          ce = cs;
          ss = cs - 32'h0000_0100;
        end
      endcase
      set_windows(cs, ce, ss);
      for (int n = 0; n < 50; n++) begin
        jitter = (rand_below(17) << 3) - 32'd64 + (rand_word() & 32'h7);
        case (rand_below(6))
          0:       addr = win_cs + jitter;
          1:       addr = win_ce + jitter;
          2:       addr = win_ss + jitter;
          3:       addr = win_ss + SpmBytes + jitter;
          4:       addr = win_ss + (rand_word() & 32'h0001_ffff);
          default: addr = rand_word();
        endcase
        issue_request(addr, 1'(rand_word()));
        gap = rand_below(4);
        if (gap > 0) begin
          req_valid_i = 1'b0;
          step();
          check_bit("decode valid idle", 1'b0, dec_valid_o);
          repeat (gap - 1) step();
        end
      end
      req_valid_i = 1'b0;
      step();
    end
    finish_test();

    test_name = "counters";
    set_windows(CachedStartReset, CachedEndReset, SpmStartReset);
    for (int n = 0; n < 80; n++) begin
      case (rand_below(3))
        0:       addr = win_cs + (rand_word() & 32'h07ff_fff8);
        1:       addr = win_ss + (rand_word() & 32'h0001_fff8);
        default: addr = 32'h1000_0000 + (rand_word() & 32'h0fff_ffff);
      endcase
      issue_request(addr, 1'(rand_word()));
      if (rand_below(2) != 0) begin
        req_valid_i = 1'b0;
        step();
      end
    end
    req_valid_i = 1'b0;
    repeat (2) step();
    for (int i = 0; i < NumCnt; i++) begin
      read_expect("counter after burst", AddrCntCachedRd + 32'(i * 4), exp_cnt[i]);
    end
    for (int i = 0; i < NumCnt; i++) begin
      reg_write(AddrCntCachedRd + 32'(i * 4), rand_word(), rand_below(MaxRespDelay + 1));
      exp_cnt[i] = '0;
      read_expect("counter after clear", AddrCntCachedRd + 32'(i * 4), 32'h0);
    end
    // Clear lands on the same edge as the increment
    issue_request(win_cs + 32'h0000_0040, 1'b0);
    req_valid_i = 1'b0;
    wr_valid_i  = 1'b1;
    wr_addr_i   = AddrCntCachedRd;
    wr_data_i   = rand_word();
    if (!wr_ready_o) note_error("write ready low before the coincident clear");
    step();
    wr_valid_i      = 1'b0;
    wr_resp_ready_i = 1'b1;
    step();
    wr_resp_ready_i = 1'b0;
    exp_cnt[CntCachedRd] = '0;
    read_expect("counter after coincident clear", AddrCntCachedRd, 32'h0);
    finish_test();

    test_name = "dma_event";
    rises  = 0;
    pulses = 0;
    for (int p = 0; p < DmaPulses; p++) begin
      len = 1 + rand_below(8);
      gap = 4 + rand_below(8);
      repeat (len) dma_cycle(1'b1, rises, pulses);
      repeat (gap) dma_cycle(1'b0, rises, pulses);
    end
    repeat (4) dma_cycle(1'b0, rises, pulses);
    check_word("pulse count", 32'(rises), 32'(pulses));
    finish_test();

    $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+dv
src/llc_cfg_pkg.sv
src/llc_geom_pkg.sv
src/llc_cfg_regs.sv
src/llc_region_decoder.sv
src/llc_access_counters.sv
src/dma_evt_rx.sv
src/host_llc_ctrl.sv
dv/tb_host_llc_ctrl.sv

// File: src/dma_evt_rx.sv
// Cluster DMA event receiver
`timescale 1ns/1ps
`default_nettype none

module dma_evt_rx (
  input  logic clk_i,
  input  logic reset_i,
  input  logic valid_i,
  output logic valid_o,
  output logic ack_o
);

  logic sync1_q;
  logic sync2_q;
  logic dly_q;

  // Two-flop synchronizer, then one more flop for edge detect
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sync1_q <= 1'b0;
      sync2_q <= 1'b0;
      dly_q   <= 1'b0;
    end else begin
      sync1_q <= valid_i;
      sync2_q <= sync1_q;
      dly_q   <= sync2_q;
    end
  end

  assign valid_o = sync2_q & ~dly_q;
  assign ack_o   = sync2_q;

endmodule

`default_nettype wire

// File: src/host_llc_ctrl.sv
// Host memory-region controller top
`timescale 1ns/1ps
`default_nettype none

module host_llc_ctrl
  import llc_cfg_pkg::*;
  import llc_geom_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     reset_i,
  // Register write
  input  logic                     wr_valid_i,
  input  logic [LiteAddrWidth-1:0] wr_addr_i,
  input  logic [LiteDataWidth-1:0] wr_data_i,
  output logic                     wr_ready_o,
  output logic                     wr_resp_valid_o,
  input  logic                     wr_resp_ready_i,
  // Register read
  input  logic                     rd_valid_i,
  input  logic [LiteAddrWidth-1:0] rd_addr_i,
  output logic                     rd_ready_o,
  output logic                     rd_resp_valid_o,
  output logic [LiteDataWidth-1:0] rd_data_o,
  input  logic                     rd_resp_ready_i,
  // Memory requests
  input  logic                     req_valid_i,
  input  logic                     req_we_i,
  input  logic [AddrBits-1:0]      req_addr_i,
  output logic                     dec_valid_o,
  output logic                     dec_we_o,
  output logic [RegionBits-1:0]    dec_region_o,
  output logic [TagBits-1:0]       dec_tag_o,
  output logic [WayBits-1:0]       dec_way_o,
  output logic [LineBits-1:0]      dec_line_o,
  output logic [BlockBits-1:0]     dec_block_o,
  // Cluster DMA event
  input  logic                     dma_evt_valid_i,
  output logic                     dma_evt_o,
  output logic                     dma_evt_ack_o
);

  logic [NumCnt-1:0][LiteDataWidth-1:0] cnt;
  logic [NumCnt-1:0]                    cnt_clear;
  logic [LiteDataWidth-1:0]             cached_start;
  logic [LiteDataWidth-1:0]             cached_end;
  logic [LiteDataWidth-1:0]             spm_start;

  llc_cfg_regs i_llc_cfg_regs (
    .clk_i           ( clk_i           ),
    .reset_i         ( reset_i         ),
    .wr_valid_i      ( wr_valid_i      ),
    .wr_addr_i       ( wr_addr_i       ),
    .wr_data_i       ( wr_data_i       ),
    .wr_ready_o      ( wr_ready_o      ),
    .wr_resp_valid_o ( wr_resp_valid_o ),
    .wr_resp_ready_i ( wr_resp_ready_i ),
    .rd_valid_i      ( rd_valid_i      ),
    .rd_addr_i       ( rd_addr_i       ),
    .rd_ready_o      ( rd_ready_o      ),
    .rd_resp_valid_o ( rd_resp_valid_o ),
    .rd_data_o       ( rd_data_o       ),
    .rd_resp_ready_i ( rd_resp_ready_i ),
    .cnt_i           ( cnt             ),
    .cnt_clear_o     ( cnt_clear       ),
    .cached_start_o  ( cached_start    ),
    .cached_end_o    ( cached_end      ),
    .spm_start_o     ( spm_start       )
  );

  llc_region_decoder i_llc_region_decoder (
    .clk_i          ( clk_i        ),
    .reset_i        ( reset_i      ),
    .req_valid_i    ( req_valid_i  ),
    .req_we_i       ( req_we_i     ),
    .req_addr_i     ( req_addr_i   ),
    .cached_start_i ( cached_start ),
    .cached_end_i   ( cached_end   ),
    .spm_start_i    ( spm_start    ),
    .dec_valid_o    ( dec_valid_o  ),
    .dec_we_o       ( dec_we_o     ),
    .dec_region_o   ( dec_region_o ),
    .dec_tag_o      ( dec_tag_o    ),
    .dec_way_o      ( dec_way_o    ),
    .dec_line_o     ( dec_line_o   ),
    .dec_block_o    ( dec_block_o  )
  );

  llc_access_counters i_llc_access_counters (
    .clk_i        ( clk_i        ),
    .reset_i      ( reset_i      ),
    .dec_valid_i  ( dec_valid_o  ),
    .dec_we_i     ( dec_we_o     ),
    .dec_region_i ( dec_region_o ),
    .cnt_clear_i  ( cnt_clear    ),
    .cnt_o        ( cnt          )
  );

  dma_evt_rx i_dma_evt_rx (
    .clk_i   ( clk_i           ),
    .reset_i ( reset_i         ),
    .valid_i ( dma_evt_valid_i ),
    .valid_o ( dma_evt_o       ),
    .ack_o   ( dma_evt_ack_o   )
  );

endmodule

`default_nettype wire

// File: src/llc_access_counters.sv
// LLC access event counters
`timescale 1ns/1ps
`default_nettype none

module llc_access_counters
  import llc_cfg_pkg::*;
  import llc_geom_pkg::*;
(
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic                                  dec_valid_i,
  input  logic                                  dec_we_i,
  input  logic [RegionBits-1:0]                 dec_region_i,
  input  logic [NumCnt-1:0]                     cnt_clear_i,
  output logic [NumCnt-1:0][LiteDataWidth-1:0]  cnt_o
);

  logic [NumCnt-1:0] inc;

  // Scratchpad and bypass count both directions
  always_comb begin
    inc = '0;
    if (dec_valid_i) begin
      case (dec_region_i)
        RegionCached: begin
          inc[CntCachedRd] = ~dec_we_i;
          inc[CntCachedWr] = dec_we_i;
        end
        RegionSpm: inc[CntSpm] = 1'b1;
        default:   inc[CntBypass] = 1'b1;
      endcase
    end
  end

  for (genvar i = 0; i < NumCnt; i++) begin : gen_cnt
    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        cnt_o[i] <= '0;
      end else if (cnt_clear_i[i]) begin
        cnt_o[i] <= '0;
      end else if (inc[i]) begin
        cnt_o[i] <= cnt_o[i] + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/llc_cfg_pkg.sv
// LLC configuration register map
`default_nettype none

package llc_cfg_pkg;

  // Register bus widths
  localparam int unsigned LiteAddrWidth = 32;
  localparam int unsigned LiteDataWidth = 32;

  // Window registers
  localparam logic [LiteAddrWidth-1:0] AddrCachedStart = 32'h0000_0000;
  localparam logic [LiteAddrWidth-1:0] AddrCachedEnd   = 32'h0000_0004;
  localparam logic [LiteAddrWidth-1:0] AddrSpmStart    = 32'h0000_0008;

  // Access counters, cleared on any write
  localparam logic [LiteAddrWidth-1:0] AddrCntCachedRd = 32'h0000_0010;
  localparam logic [LiteAddrWidth-1:0] AddrCntCachedWr = 32'h0000_0014;
  localparam logic [LiteAddrWidth-1:0] AddrCntSpm      = 32'h0000_0018;
  localparam logic [LiteAddrWidth-1:0] AddrCntBypass   = 32'h0000_001C;

  // Counter slots in the counter array
  localparam int unsigned NumCnt      = 4;
  localparam int unsigned CntCachedRd = 0;
  localparam int unsigned CntCachedWr = 1;
  localparam int unsigned CntSpm      = 2;
  localparam int unsigned CntBypass   = 3;

  localparam logic [LiteDataWidth-1:0] UnmappedData = 32'hdeadf000;

  // Window reset values
  localparam logic [LiteDataWidth-1:0] CachedStartReset = 32'h8000_0000;
  localparam logic [LiteDataWidth-1:0] CachedEndReset   = 32'h8800_0000;
  localparam logic [LiteDataWidth-1:0] SpmStartReset    = 32'h7000_0000;

endpackage

`default_nettype wire

// File: src/llc_cfg_regs.sv
// LLC configuration register slave
`timescale 1ns/1ps
`default_nettype none

module llc_cfg_regs
  import llc_cfg_pkg::*;
(
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic                                  wr_valid_i,
  input  logic [LiteAddrWidth-1:0]              wr_addr_i,
  input  logic [LiteDataWidth-1:0]              wr_data_i,
  output logic                                  wr_ready_o,
  output logic                                  wr_resp_valid_o,
  input  logic                                  wr_resp_ready_i,
  input  logic                                  rd_valid_i,
  input  logic [LiteAddrWidth-1:0]              rd_addr_i,
  output logic                                  rd_ready_o,
  output logic                                  rd_resp_valid_o,
  output logic [LiteDataWidth-1:0]              rd_data_o,
  input  logic                                  rd_resp_ready_i,
  input  logic [NumCnt-1:0][LiteDataWidth-1:0]  cnt_i,
  output logic [NumCnt-1:0]                     cnt_clear_o,
  output logic [LiteDataWidth-1:0]              cached_start_o,
  output logic [LiteDataWidth-1:0]              cached_end_o,
  output logic [LiteDataWidth-1:0]              spm_start_o
);

  logic                     wr_pend_q;
  logic                     rd_pend_q;
  logic                     wr_accept;
  logic                     rd_accept;
  logic [LiteDataWidth-1:0] rd_data_d;
  logic [LiteDataWidth-1:0] rd_data_q;
  logic [LiteDataWidth-1:0] cached_start_q;
  logic [LiteDataWidth-1:0] cached_end_q;
  logic [LiteDataWidth-1:0] spm_start_q;

  // One outstanding response per direction
  assign wr_ready_o = ~wr_pend_q;
  assign rd_ready_o = ~rd_pend_q;
  assign wr_accept  = wr_valid_i & wr_ready_o;
  assign rd_accept  = rd_valid_i & rd_ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_pend_q <= 1'b0;
      rd_pend_q <= 1'b0;
    end else begin
      if (wr_accept) begin
        wr_pend_q <= 1'b1;
      end else if (wr_resp_ready_i) begin
        wr_pend_q <= 1'b0;
      end
      if (rd_accept) begin
        rd_pend_q <= 1'b1;
      end else if (rd_resp_ready_i) begin
        rd_pend_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cached_start_q <= CachedStartReset;
      cached_end_q   <= CachedEndReset;
      spm_start_q    <= SpmStartReset;
    end else if (wr_accept) begin
      case (wr_addr_i)
        AddrCachedStart: cached_start_q <= wr_data_i;
        AddrCachedEnd:   cached_end_q   <= wr_data_i;
        AddrSpmStart:    spm_start_q    <= wr_data_i;
        default: ;
      endcase
    end
  end

  // Counter writes only clear, data is ignored
  always_comb begin
    cnt_clear_o = '0;
    if (wr_accept) begin
      case (wr_addr_i)
        AddrCntCachedRd: cnt_clear_o[CntCachedRd] = 1'b1;
        AddrCntCachedWr: cnt_clear_o[CntCachedWr] = 1'b1;
        AddrCntSpm:      cnt_clear_o[CntSpm]      = 1'b1;
        AddrCntBypass:   cnt_clear_o[CntBypass]   = 1'b1;
        default: ;
      endcase
    end
  end

  always_comb begin
    case (rd_addr_i)
      AddrCachedStart: rd_data_d = cached_start_q;
      AddrCachedEnd:   rd_data_d = cached_end_q;
      AddrSpmStart:    rd_data_d = spm_start_q;
      AddrCntCachedRd: rd_data_d = cnt_i[CntCachedRd];
      AddrCntCachedWr: rd_data_d = cnt_i[CntCachedWr];
      AddrCntSpm:      rd_data_d = cnt_i[CntSpm];
      AddrCntBypass:   rd_data_d = cnt_i[CntBypass];
      default:         rd_data_d = UnmappedData;
    endcase
  end

  // Held until the response is taken
  always_ff @(posedge clk_i) begin
    if (rd_accept) begin
      rd_data_q <= rd_data_d;
    end
  end

  assign wr_resp_valid_o = wr_pend_q;
  assign rd_resp_valid_o = rd_pend_q;
  assign rd_data_o       = rd_data_q;
  assign cached_start_o  = cached_start_q;
  assign cached_end_o    = cached_end_q;
  assign spm_start_o     = spm_start_q;

endmodule

`default_nettype wire

// File: src/llc_geom_pkg.sv
// LLC geometry and address views
`default_nettype none

package llc_geom_pkg;

  localparam int unsigned AddrBits = 32;

  // 8 ways, 256 lines, 8 blocks of 64 bits
  localparam int unsigned NumWays    = 8;
  localparam int unsigned NumLines   = 256;
  localparam int unsigned NumBlocks  = 8;
  localparam int unsigned BlockBytes = 8;

  localparam int unsigned ByteBits   = $clog2(BlockBytes);
  localparam int unsigned BlockBits  = $clog2(NumBlocks);
  localparam int unsigned LineBits   = $clog2(NumLines);
  localparam int unsigned WayBits    = $clog2(NumWays);
  localparam int unsigned TagBits    = AddrBits - LineBits - BlockBits - ByteBits;
  localparam int unsigned SpmPadBits = TagBits - WayBits;

  // Scratchpad covers the whole data array
  localparam logic [AddrBits-1:0] SpmBytes = NumWays * NumLines * NumBlocks * BlockBytes;

  localparam int unsigned RegionBits = 2;
  localparam logic [RegionBits-1:0] RegionBypass = 2'd0;
  localparam logic [RegionBits-1:0] RegionCached = 2'd1;
  localparam logic [RegionBits-1:0] RegionSpm    = 2'd2;

  typedef struct packed {
    logic [TagBits-1:0]   tag;
    logic [LineBits-1:0]  line;
    logic [BlockBits-1:0] block;
    logic [ByteBits-1:0]  offset;
  } llc_cache_view_t;

  // Offset from scratchpad start
  typedef struct packed {
    logic [SpmPadBits-1:0] unused;
    logic [WayBits-1:0]    way;
    logic [LineBits-1:0]   line;
    logic [BlockBits-1:0]  block;
    logic [ByteBits-1:0]   offset;
  } llc_spm_view_t;

  typedef union packed {
    llc_cache_view_t cache;
    llc_spm_view_t   spm;
  } llc_addr_u;

endpackage

`default_nettype wire

// File: src/llc_region_decoder.sv
// LLC request region decoder
`timescale 1ns/1ps
`default_nettype none

module llc_region_decoder
  import llc_geom_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  req_valid_i,
  input  logic                  req_we_i,
  input  logic [AddrBits-1:0]   req_addr_i,
  input  logic [AddrBits-1:0]   cached_start_i,
  input  logic [AddrBits-1:0]   cached_end_i,
  input  logic [AddrBits-1:0]   spm_start_i,
  output logic                  dec_valid_o,
  output logic                  dec_we_o,
  output logic [RegionBits-1:0] dec_region_o,
  output logic [TagBits-1:0]    dec_tag_o,
  output logic [WayBits-1:0]    dec_way_o,
  output logic [LineBits-1:0]   dec_line_o,
  output logic [BlockBits-1:0]  dec_block_o
);

  llc_addr_u             addr_u;
  llc_addr_u             off_u;
  logic [AddrBits-1:0]   spm_off;
  logic                  in_cached;
  logic                  in_spm;
  logic [RegionBits-1:0] region_d;
  logic [TagBits-1:0]    tag_d;
  logic [WayBits-1:0]    way_d;
  logic [LineBits-1:0]   line_d;
  logic [BlockBits-1:0]  block_d;

  // Wrapping difference, so addresses below the start fall out too
  assign spm_off   = req_addr_i - spm_start_i;
  assign addr_u    = req_addr_i;
  assign off_u     = spm_off;
  assign in_cached = (req_addr_i >= cached_start_i) && (req_addr_i < cached_end_i);
  assign in_spm    = spm_off < SpmBytes;

  always_comb begin
    region_d = RegionBypass;
    tag_d    = '0;
    way_d    = '0;
    line_d   = '0;
    block_d  = '0;
    if (in_cached) begin
      region_d = RegionCached;
      tag_d    = addr_u.cache.tag;
      line_d   = addr_u.cache.line;
      block_d  = addr_u.cache.block;
    end else if (in_spm) begin
      region_d = RegionSpm;
      way_d    = off_u.spm.way;
      line_d   = off_u.spm.line;
      block_d  = off_u.spm.block;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      dec_valid_o <= 1'b0;
    end else begin
      dec_valid_o <= req_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      dec_we_o     <= req_we_i;
      dec_region_o <= region_d;
      dec_tag_o    <= tag_d;
      dec_way_o    <= way_d;
      dec_line_o   <= line_d;
      dec_block_o  <= block_d;
    end
  end

endmodule

`default_nettype wire
